// ==== Makefile ====
TOP = tb_cnn_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== design/axil_cmd_port.sv ====
`timescale 1ns/1ns

module axil_cmd_port (
    input  logic                                clk,
    input  logic                                rst,
    // Write address and data
    input  logic                                i_awvalid,
    input  logic [csb_pkg::AXIL_ADDR_W-1:0]     i_awaddr,
    output logic                                o_awready,
    input  logic                                i_wvalid,
    input  logic [31:0]                         i_wdata,
    output logic                                o_wready,
    // Write response
    output logic                                o_bvalid,
    output logic [1:0]                          o_bresp,
    input  logic                                i_bready,
    // Read address and data
    input  logic                                i_arvalid,
    input  logic [csb_pkg::AXIL_ADDR_W-1:0]     i_araddr,
    output logic                                o_arready,
    output logic                                o_rvalid,
    output logic [31:0]                         o_rdata,
    output logic [1:0]                          o_rresp,
    input  logic                                i_rready,
    // Core side
    input  csb_pkg::csb_state_e                 i_state,
    input  logic                                i_done,
    input  logic                                i_win_push,
    output logic                                o_op_en,
    fifo_if.writer                              cmd_w
);

    logic        wr_hs;
    logic        rd_hs;
    logic        done_flag;
    logic [31:0] win_count;

    // Both channels accepted in the same cycle
    assign wr_hs = o_awready && i_awvalid && o_wready && i_wvalid;
    assign rd_hs = o_arready && i_arvalid;

    // Command word goes straight into the FIFO, never when full
    assign cmd_w.wr_en = wr_hs && (i_awaddr == csb_pkg::ADDR_CMD) && !cmd_w.full;
    assign cmd_w.wr_data = i_wdata;

    assign o_rresp = csb_pkg::RESP_OKAY;

    // Write channel handshake and response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_awready <= 1'b0;
            o_wready <= 1'b0;
            o_bvalid <= 1'b0;
            o_op_en <= 1'b0;
        end else begin
            // Ready is a one-cycle pulse once both valids are up
            if (o_awready) begin
                o_awready <= 1'b0;
                o_wready <= 1'b0;
            end else if (i_awvalid && i_wvalid && !o_bvalid) begin
                o_awready <= 1'b1;
                o_wready <= 1'b1;
            end
            if (wr_hs) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            // Start strobe from bit 0 of the status register
            o_op_en <= wr_hs && (i_awaddr == csb_pkg::ADDR_STATUS) && i_wdata[0];
        end
    end

    // SLVERR only for a command word that found the FIFO full
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            if ((i_awaddr == csb_pkg::ADDR_CMD) && cmd_w.full) begin
                o_bresp <= csb_pkg::RESP_SLVERR;
            end else begin
                o_bresp <= csb_pkg::RESP_OKAY;
            end
        end
    end

    // Sticky done and window count, both cleared by a new start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_flag <= 1'b0;
            win_count <= '0;
        end else if (o_op_en) begin
            done_flag <= 1'b0;
            win_count <= '0;
        end else begin
            if (i_done) begin
                done_flag <= 1'b1;
            end
            if (i_win_push) begin
                win_count <= win_count + 1'b1;
            end
        end
    end

    // Read channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_arready <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            o_arready <= i_arvalid && !o_arready && !o_rvalid;
            if (rd_hs) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // Read data registered on the address handshake
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (i_araddr)
                csb_pkg::ADDR_STATUS: o_rdata <= {23'd0, done_flag, 5'd0, i_state};
                csb_pkg::ADDR_COUNT:  o_rdata <= win_count;
                default:              o_rdata <= '0;
            endcase
        end
    end

    // Response and its code held until the host takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
        else $error("axil_cmd_port: write response changed before bready");

endmodule

// ==== design/cnn_ctrl_top.sv ====
`timescale 1ns/1ns

module cnn_ctrl_top (
    input  logic                                clk,
    input  logic                                rst,
    // AXI4-Lite slave
    input  logic                                i_awvalid,
    input  logic [csb_pkg::AXIL_ADDR_W-1:0]     i_awaddr,
    output logic                                o_awready,
    input  logic                                i_wvalid,
    input  logic [31:0]                         i_wdata,
    output logic                                o_wready,
    output logic                                o_bvalid,
    output logic [1:0]                          o_bresp,
    input  logic                                i_bready,
    input  logic                                i_arvalid,
    input  logic [csb_pkg::AXIL_ADDR_W-1:0]     i_araddr,
    output logic                                o_arready,
    output logic                                o_rvalid,
    output logic [31:0]                         o_rdata,
    output logic [1:0]                          o_rresp,
    input  logic                                i_rready,
    // Window origin stream
    output logic                                o_win_valid,
    output csb_pkg::win_t                       o_win_data,
    input  logic                                i_win_ready
);

    csb_pkg::op_desc_t   desc;
    csb_pkg::csb_state_e state;
    logic                op_en;
    logic                start;
    logic                done;
    logic                win_push;

    fifo_if #(.T(logic [31:0])) cmd_q ();
    fifo_if #(.T(csb_pkg::win_t)) win_q ();

    // Window FIFO head drives the stream directly
    assign o_win_valid = !win_q.empty;
    assign o_win_data = win_q.rd_data;
    assign win_q.rd_en = i_win_ready && !win_q.empty;

    axil_cmd_port u_port (
        .clk, .rst,
        .i_awvalid, .i_awaddr, .o_awready,
        .i_wvalid, .i_wdata, .o_wready,
        .o_bvalid, .o_bresp, .i_bready,
        .i_arvalid, .i_araddr, .o_arready,
        .o_rvalid, .o_rdata, .o_rresp, .i_rready,
        .i_state(state), .i_done(done), .i_win_push(win_push),
        .o_op_en(op_en), .cmd_w(cmd_q)
    );

    sync_fifo #(.T(logic [31:0]), .DEPTH(csb_pkg::CMD_FIFO_DEPTH)) cmd_fifo (
        .clk, .rst, .io_q(cmd_q)
    );

    csb u_csb (
        .clk, .rst,
        .i_op_en(op_en), .i_done(done), .cmd_r(cmd_q),
        .o_desc(desc), .o_start(start), .o_state(state)
    );

    window_seq u_seq (
        .clk, .rst,
        .i_start(start), .i_desc(desc),
        .o_done(done), .o_push(win_push), .win_w(win_q)
    );

    sync_fifo #(.T(csb_pkg::win_t), .DEPTH(csb_pkg::WIN_FIFO_DEPTH)) win_fifo (
        .clk, .rst, .io_q(win_q)
    );

endmodule

// ==== design/csb.sv ====
`timescale 1ns/1ns

module csb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_op_en,
    input  logic                  i_done,
    fifo_if.reader                cmd_r,
    output csb_pkg::op_desc_t     o_desc,
    output logic                  o_start,
    output csb_pkg::csb_state_e   o_state
);

    localparam logic [csb_pkg::CMD_CNT_W-1:0] LAST_WORD =
        csb_pkg::CMD_CNT_W'(csb_pkg::CMD_BURST_LEN - 1);

    csb_pkg::csb_state_e            state;
    csb_pkg::csb_state_e            next_state;
    logic [csb_pkg::CMD_CNT_W-1:0]  burst_cnt;
    logic                           pop;

    assign o_state = state;

    // One word per cycle while collecting and data is there
    assign pop = (state == csb_pkg::ST_CMD_GET) && !cmd_r.empty;
    assign cmd_r.rd_en = pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= csb_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csb_pkg::ST_IDLE: begin
                if (i_op_en) begin
                    next_state = csb_pkg::ST_CMD_GET;
                end
            end
            csb_pkg::ST_CMD_GET: begin
                // Leave on the last word of the burst
                if (pop && (burst_cnt == LAST_WORD)) begin
                    next_state = csb_pkg::ST_OP_RUN;
                end
            end
            csb_pkg::ST_OP_RUN: begin
                // Sequencer finished, ready for the next command
                if (i_done) begin
                    next_state = csb_pkg::ST_IDLE;
                end
            end
            default: begin
                next_state = csb_pkg::ST_IDLE;
            end
        endcase
    end

    // Burst word counter and start pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst_cnt <= '0;
            o_start <= 1'b0;
        end else begin
            o_start <= pop && (burst_cnt == LAST_WORD);
            if (state != csb_pkg::ST_CMD_GET) begin
                burst_cnt <= '0;
            end else if (pop) begin
                burst_cnt <= (burst_cnt == LAST_WORD) ? '0 : burst_cnt + 1'b1;
            end
        end
    end

    // Field split; loads only during the burst so it holds while running
    always_ff @(posedge clk) begin
        if (pop) begin
            case (burst_cnt)
                2'd0: begin
                    o_desc.op_type <= csb_pkg::op_type_e'(cmd_r.rd_data[2:0]);
                    o_desc.stride <= cmd_r.rd_data[7:4];
                    o_desc.kernel <= cmd_r.rd_data[15:8];
                    o_desc.i_side <= cmd_r.rd_data[23:16];
                    o_desc.o_side <= cmd_r.rd_data[31:24];
                end
                2'd1: begin
                    o_desc.i_channel <= cmd_r.rd_data[15:0];
                    o_desc.o_channel <= cmd_r.rd_data[31:16];
                end
                2'd2: begin
                    // Bits 7:0 of word 2 are reserved
                    o_desc.kernel_size <= cmd_r.rd_data[15:8];
                    o_desc.stride2 <= cmd_r.rd_data[31:16];
                end
                default: begin
                end
            endcase
        end
    end

    // Start only in the first cycle of op-run
    a_start_on_entry: assert property (@(posedge clk) disable iff (rst)
        o_start |-> (state == csb_pkg::ST_OP_RUN) && ($past(state) == csb_pkg::ST_CMD_GET))
        else $error("csb: start outside op-run entry");

endmodule

// ==== design/csb_pkg.sv ====
package csb_pkg;

    // Command words per operation
    localparam int CMD_BURST_LEN = 3;
    localparam int CMD_CNT_W = $clog2(CMD_BURST_LEN);

    // FIFO depths
    localparam int CMD_FIFO_DEPTH = 8;
    localparam int WIN_FIFO_DEPTH = 4;

    // AXI4-Lite register map
    localparam int AXIL_ADDR_W = 4;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CMD = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_COUNT = 4'h8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_type_e;

    // Decoder state, visible in status bits 2:0
    typedef enum logic [2:0] {
        ST_IDLE    = 3'b000,
        ST_CMD_GET = 3'b001,
        ST_OP_RUN  = 3'b011
    } csb_state_e;

    // Decoded three-word command
    typedef struct packed {
        op_type_e    op_type;
        logic [3:0]  stride;
        logic [7:0]  kernel;
        logic [7:0]  i_side;
        logic [7:0]  o_side;
        logic [15:0] i_channel;
        logic [15:0] o_channel;
        logic [7:0]  kernel_size;
        logic [15:0] stride2;
    } op_desc_t;

    // One window origin, 32 bits
    typedef struct packed {
        logic [15:0] channel;
        logic [7:0]  row;
        logic [7:0]  col;
    } win_t;

endpackage

// ==== design/fifo_if.sv ====
`timescale 1ns/1ns

// FIFO link; T is the payload type carried
interface fifo_if #(
    parameter type T = logic [31:0]
);

    // Writer side
    logic wr_en;
    T     wr_data;
    logic full;

    // Reader side, rd_data shows the head entry
    logic rd_en;
    T     rd_data;
    logic empty;

    modport writer (
        output wr_en,
        output wr_data,
        input  full
    );

    modport reader (
        output rd_en,
        input  rd_data,
        input  empty
    );

    modport fifo (
        input  wr_en,
        input  wr_data,
        output full,
        input  rd_en,
        output rd_data,
        output empty
    );

endinterface

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 8
) (
    input logic clk,
    input logic rst,
    fifo_if.fifo io_q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Accepted transfers only
    assign push = io_q.wr_en && !io_q.full;
    assign pop = io_q.rd_en && !io_q.empty;

    assign io_q.full = (count == CNT_W'(DEPTH));
    assign io_q.empty = (count == '0);
    assign io_q.rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= io_q.wr_data;
        end
    end

    // Pointers wrap at DEPTH, also for odd depths
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy moves only when one side acts alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Writers must look at full before pushing
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        io_q.wr_en |-> !io_q.full)
        else $error("sync_fifo: push while full");

    // Readers must look at empty before popping
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        io_q.rd_en |-> !io_q.empty)
        else $error("sync_fifo: pop while empty");

endmodule

// ==== design/window_seq.sv ====
`timescale 1ns/1ns

module window_seq (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_start,
    input  csb_pkg::op_desc_t   i_desc,
    output logic                o_done,
    output logic                o_push,
    fifo_if.writer              win_w
);

    logic        active;
    logic        push;
    logic        col_last;
    logic        row_last;
    logic        ch_last;
    logic        no_work;
    logic [15:0] ch;
    logic [7:0]  orow;
    logic [7:0]  ocol;
    // Running origins, row and column times stride
    logic [7:0]  row_org;
    logic [7:0]  col_org;

    // Nothing to do for idle ops or an empty output
    assign no_work = (i_desc.op_type == csb_pkg::OP_IDLE) ||
                     (i_desc.o_side == 8'd0) || (i_desc.o_channel == 16'd0);

    // Hold everything while the window FIFO is full
    assign push = active && !win_w.full;
    assign win_w.wr_en = push;
    assign win_w.wr_data = '{channel: ch, row: row_org, col: col_org};
    assign o_push = push;

    assign col_last = (ocol == i_desc.o_side - 8'd1);
    assign row_last = (orow == i_desc.o_side - 8'd1);
    assign ch_last = (ch == i_desc.o_channel - 16'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            o_done <= 1'b0;
            ch <= '0;
            orow <= '0;
            ocol <= '0;
            row_org <= '0;
            col_org <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                ch <= '0;
                orow <= '0;
                ocol <= '0;
                row_org <= '0;
                col_org <= '0;
                // Empty ops finish right away
                active <= !no_work;
                o_done <= no_work;
            end else if (push) begin
                // Column innermost, then row, then channel
                if (!col_last) begin
                    ocol <= ocol + 8'd1;
                    col_org <= col_org + {4'd0, i_desc.stride};
                end else begin
                    ocol <= '0;
                    col_org <= '0;
                    if (!row_last) begin
                        orow <= orow + 8'd1;
                        row_org <= row_org + {4'd0, i_desc.stride};
                    end else begin
                        orow <= '0;
                        row_org <= '0;
                        if (!ch_last) begin
                            ch <= ch + 16'd1;
                        end else begin
                            // Last window went out this cycle
                            active <= 1'b0;
                            o_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== src.f ====
design/csb_pkg.sv
design/fifo_if.sv
design/sync_fifo.sv
design/axil_cmd_port.sv
design/csb.sv
design/window_seq.sv
design/cnn_ctrl_top.sv
testbench/tb_cnn_ctrl.sv

// ==== testbench/cnn_ctrl_testdata.txt ====
// First entry is the number of tests, then one test per line
// Columns: word0 word1 word2 expected_count expected_last_window random_ready
6
// Conv, stride 1, o_side 3, o_channel 2
03050311 00020001 00010300 00000012 00010202 00000000
// Max pool, stride 2, o_side 4
04080224 00010001 00020200 00000010 00000606 00000000
// Avg pool, stride 3, three channels, random ready
030b0335 00030003 00030300 0000001b 00020606 00000001
// Idle op, no windows
03050310 00020001 00010300 00000000 00000000 00000000
// Conv with zero output channels
03050311 00000001 00010300 00000000 00000000 00000000
// Normal conv after the empty ones, random ready
02040211 00010001 00010200 00000004 00000101 00000001

// ==== testbench/tb_cnn_ctrl.sv ====
`timescale 1ns/1ns

module tb_cnn_ctrl;

    localparam int TIMEOUT = 2000;
    // Words per test line in the data file
    localparam int COLS = 6;

    logic          clk;
    logic          rst;
    logic          i_awvalid;
    logic [3:0]    i_awaddr;
    logic          o_awready;
    logic          i_wvalid;
    logic [31:0]   i_wdata;
    logic          o_wready;
    logic          o_bvalid;
    logic [1:0]    o_bresp;
    logic          i_bready;
    logic          i_arvalid;
    logic [3:0]    i_araddr;
    logic          o_arready;
    logic          o_rvalid;
    logic [31:0]   o_rdata;
    logic [1:0]    o_rresp;
    logic          i_rready;
    logic          o_win_valid;
    csb_pkg::win_t o_win_data;
    logic          i_win_ready;

    logic [31:0]   tdata [0:63];
    // Windows seen on the stream and windows from the loop model
    logic [31:0]   got_q [$];
    logic [31:0]   exp_q [$];
    logic          rand_ready;
    integer        seed;
    int            errors;
    int            checks;
    int            tests;
    int            failed_tests;

    cnn_ctrl_top DUT (
        .clk, .rst,
        .i_awvalid, .i_awaddr, .o_awready,
        .i_wvalid, .i_wdata, .o_wready,
        .o_bvalid, .o_bresp, .i_bready,
        .i_arvalid, .i_araddr, .o_arready,
        .o_rvalid, .o_rdata, .o_rresp, .i_rready,
        .o_win_valid, .o_win_data, .i_win_ready
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Stream ready, random when the test asks for it
    initial begin
        i_win_ready = 1'b0;
        seed = 32'hb275_8693;
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                i_win_ready = 1'($random(seed));
            end else begin
                i_win_ready = 1'b1;
            end
        end
    end

    // Mid-cycle sample, transfer lands on the next rising edge
    always @(negedge clk) begin
        if (o_win_valid && i_win_ready) begin
            got_q.push_back(o_win_data);
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Error at %0t: timed out waiting for %s", $time, what);
        errors++;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int t;
        t = 0;
        i_awvalid = 1'b1;
        i_awaddr = addr;
        i_wvalid = 1'b1;
        i_wdata = data;
        while (!o_awready && t < TIMEOUT) begin
            step();
            t++;
        end
        if (!o_awready) begin
            timeout_error("write address ready");
        end
        // Data channel ready comes with the address channel
        check_value("o_wready", {31'd0, o_wready}, 32'd1);
        // Handshake on this edge
        step();
        i_awvalid = 1'b0;
        i_wvalid = 1'b0;
        t = 0;
        while (!o_bvalid && t < TIMEOUT) begin
            step();
            t++;
        end
        if (!o_bvalid) begin
            timeout_error("write response");
        end
        resp = o_bresp;
        i_bready = 1'b1;
        step();
        i_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int t;
        t = 0;
        i_arvalid = 1'b1;
        i_araddr = addr;
        while (!o_arready && t < TIMEOUT) begin
            step();
            t++;
        end
        if (!o_arready) begin
            timeout_error("read address ready");
        end
        step();
        i_arvalid = 1'b0;
        t = 0;
        while (!o_rvalid && t < TIMEOUT) begin
            step();
            t++;
        end
        if (!o_rvalid) begin
            timeout_error("read data");
        end
        data = o_rdata;
        check_value("o_rresp", {30'd0, o_rresp}, 32'd0);
        i_rready = 1'b1;
        step();
        i_rready = 1'b0;
    endtask

    // Channel outer, row, column inner; origin is position times stride
    task automatic build_expected(input logic [31:0] w0, input logic [31:0] w1);
        int stride;
        int side;
        int chans;
        exp_q.delete();
        stride = int'(w0[7:4]);
        side = int'(w0[31:24]);
        chans = int'(w1[31:16]);
        // Idle op emits nothing
        if (w0[2:0] == 3'b000) begin
            chans = 0;
        end
        for (int ch = 0; ch < chans; ch++) begin
            for (int r = 0; r < side; r++) begin
                for (int c = 0; c < side; c++) begin
                    exp_q.push_back({16'(ch), 8'(r * stride), 8'(c * stride)});
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic run_file_test(input int n);
        logic [31:0] words [3];
        logic [31:0] exp_count;
        logic [31:0] exp_last;
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          base;
        int          err0;
        int          t;
        base = 1 + n * COLS;
        words[0] = tdata[base];
        words[1] = tdata[base + 1];
        words[2] = tdata[base + 2];
        exp_count = tdata[base + 3];
        exp_last = tdata[base + 4];
        err0 = errors;
        rand_ready = tdata[base + 5][0];
        got_q.delete();
        // Model against the file columns
        build_expected(words[0], words[1]);
        check_value("model window count", exp_q.size(), exp_count);
        if (exp_q.size() > 0) begin
            check_value("model last window", exp_q[$], exp_last);
        end
        for (int i = 0; i < 3; i++) begin
            axil_write(csb_pkg::ADDR_CMD, words[i], resp);
            check_value($sformatf("bresp of word %0d", i), {30'd0, resp}, 32'd0);
        end
        // Start strobe
        axil_write(csb_pkg::ADDR_STATUS, 32'd1, resp);
        check_value("bresp of start", {30'd0, resp}, 32'd0);
        rdata = '0;
        t = 0;
        while (!rdata[8] && t < TIMEOUT) begin
            axil_read(csb_pkg::ADDR_STATUS, rdata);
            t++;
        end
        if (!rdata[8]) begin
            timeout_error("done flag");
        end
        check_value("state at done", {29'd0, rdata[2:0]}, 32'd0);
        // Windows still in the output FIFO drain here
        t = 0;
        while ((got_q.size() < exp_q.size() || o_win_valid) && t < TIMEOUT) begin
            step();
            t++;
        end
        if (t >= TIMEOUT) begin
            timeout_error("window stream to drain");
        end
        check_value("window count", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value($sformatf("window %0d", i), got_q[i], exp_q[i]);
        end
        axil_read(csb_pkg::ADDR_COUNT, rdata);
        check_value("count register", rdata, exp_count);
        report_test($sformatf("file line %0d", n + 1), err0);
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          err0;
        int          ntests;
        rst = 1'b1;
        i_awvalid = 1'b0;
        i_awaddr = '0;
        i_wvalid = 1'b0;
        i_wdata = '0;
        i_bready = 1'b0;
        i_arvalid = 1'b0;
        i_araddr = '0;
        i_rready = 1'b0;
        rand_ready = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        $readmemh("testbench/cnn_ctrl_testdata.txt", tdata);

        // Idle state, done clear, no stream data
        err0 = errors;
        axil_read(csb_pkg::ADDR_STATUS, rdata);
        check_value("status after reset", rdata, 32'd0);
        check_value("o_win_valid after reset", {31'd0, o_win_valid}, 32'd0);
        report_test("reset", err0);

        ntests = int'(tdata[0]);
        for (int n = 0; n < ntests; n++) begin
            run_file_test(n);
        end

        // Fill the command FIFO with no start, one word too many
        err0 = errors;
        for (int k = 0; k < 9; k++) begin
            axil_write(csb_pkg::ADDR_CMD, 32'h0000_1000 + k, resp);
            check_value($sformatf("bresp of write %0d", k + 1), {30'd0, resp},
                        (k < csb_pkg::CMD_FIFO_DEPTH) ? 32'd0 : 32'd2);
        end
        report_test("command FIFO overflow", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
